// File: decode_stage.sv
// Instruction decode
// Control and immediate decode, register file and load-use detection
`timescale 1ns/100ps

module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  pipe_pkg::fd_t       fd,
    input  pipe_pkg::fwd_t      fwd_w,
    input  pipe_pkg::redirect_t redirect,
    input  logic                mem_stall,
    output pipe_pkg::de_t       de,
    output logic                load_use_stall
);

    isa_pkg::word_t    regs [32];
    isa_pkg::opcode_e  opcode;
    isa_pkg::reg_idx_t rs1;
    isa_pkg::reg_idx_t rs2;
    logic [6:0]        funct7;
    logic              uses_rs1;
    logic              uses_rs2;
    pipe_pkg::ctrl_t   ctrl;
    isa_pkg::word_t    imm;

    // ========================================
    // Field extraction
    // ========================================
    assign opcode = isa_pkg::opcode_e'(fd.instr[6:0]);
    assign rs1    = fd.instr[19:15];
    assign rs2    = fd.instr[24:20];
    assign funct7 = fd.instr[31:25];

    // Register read with bypass of the write in this cycle
    function automatic isa_pkg::word_t read_reg(isa_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (fwd_w.valid && fwd_w.rd == idx) begin
            return fwd_w.data;
        end
        return regs[idx];
    endfunction

    // ========================================
    // Control and immediate decode
    // ========================================
    always_comb begin
        ctrl        = '0;
        ctrl.funct3 = fd.instr[14:12];
        imm         = '0;
        uses_rs1    = 1'b1;
        uses_rs2    = 1'b0;
        case (opcode)
            isa_pkg::op_reg, isa_pkg::op_imm: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = (opcode == isa_pkg::op_imm);
                uses_rs2         = (opcode == isa_pkg::op_reg);
                imm              = {{20{fd.instr[31]}}, fd.instr[31:20]};
                case (fd.instr[14:12])
                    3'b000: ctrl.alu_op = (uses_rs2 && funct7[5]) ? isa_pkg::alu_sub
                                                                  : isa_pkg::alu_add;
                    3'b001: ctrl.alu_op = isa_pkg::alu_sll;
                    3'b010: ctrl.alu_op = isa_pkg::alu_slt;
                    3'b100: ctrl.alu_op = isa_pkg::alu_xor;
                    3'b101: ctrl.alu_op = isa_pkg::alu_srl;
                    3'b110: ctrl.alu_op = isa_pkg::alu_or;
                    default: ctrl.alu_op = isa_pkg::alu_and;
                endcase
            end
            isa_pkg::op_lui: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = isa_pkg::alu_pass_b;
                uses_rs1         = 1'b0;
                imm              = {fd.instr[31:12], 12'b0};
            end
            isa_pkg::op_load: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = {{20{fd.instr[31]}}, fd.instr[31:20]};
            end
            isa_pkg::op_store: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                uses_rs2         = 1'b1;
                imm = {{20{fd.instr[31]}}, fd.instr[31:25], fd.instr[11:7]};
            end
            isa_pkg::op_branch: begin
                ctrl.branch = 1'b1;
                uses_rs2    = 1'b1;
                imm = {{20{fd.instr[31]}}, fd.instr[7], fd.instr[30:25],
                       fd.instr[11:8], 1'b0};
            end
            isa_pkg::op_jal: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                uses_rs1       = 1'b0;
                imm = {{12{fd.instr[31]}}, fd.instr[19:12], fd.instr[20],
                       fd.instr[30:21], 1'b0};
            end
            isa_pkg::op_jalr: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.jump_reg  = 1'b1;
                ctrl.link      = 1'b1;
                imm            = {{20{fd.instr[31]}}, fd.instr[31:20]};
            end
            // Unknown opcodes retire as no-ops
            default: uses_rs1 = 1'b0;
        endcase
    end

    // Load in execute feeding the instruction now in decode
    assign load_use_stall = fd.valid && de.valid && de.ctrl.mem_read && de.rd != '0 &&
                            ((uses_rs1 && de.rd == rs1) || (uses_rs2 && de.rd == rs2));

    // Writeback port that never targets x0
    always_ff @(posedge clk) begin
        if (fwd_w.valid) begin
            regs[fwd_w.rd] <= fwd_w.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de <= '0;
        end else if (!mem_stall) begin
            if (redirect.taken || load_use_stall || !fd.valid) begin
                de <= '0;
            end else begin
                de <= '{valid: 1'b1, pc: fd.pc, rs1: rs1, rs2: rs2, rd: fd.instr[11:7],
                        rs1_data: read_reg(rs1), rs2_data: read_reg(rs2),
                        imm: imm, ctrl: ctrl};
            end
        end
    end

endmodule

// File: execute_stage.sv
// Execute stage
// Operand forwarding, ALU, branch resolution and the execute/memory register
`timescale 1ns/100ps

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  pipe_pkg::de_t       de,
    input  pipe_pkg::fwd_t      fwd_m,
    input  pipe_pkg::fwd_t      fwd_w,
    input  logic                mem_stall,
    output pipe_pkg::em_t       em,
    output pipe_pkg::redirect_t redirect
);

    isa_pkg::word_t op_a;
    isa_pkg::word_t op_b_reg;
    isa_pkg::word_t alu_b;
    isa_pkg::word_t alu_out;
    isa_pkg::word_t link_pc;
    isa_pkg::word_t target;
    logic           cond;

    // Youngest producer wins, register value last
    function automatic isa_pkg::word_t forward(isa_pkg::reg_idx_t rs, isa_pkg::word_t rval);
        if (fwd_m.valid && fwd_m.rd == rs) begin
            return fwd_m.data;
        end
        if (fwd_w.valid && fwd_w.rd == rs) begin
            return fwd_w.data;
        end
        return rval;
    endfunction

    assign op_a     = forward(de.rs1, de.rs1_data);
    assign op_b_reg = forward(de.rs2, de.rs2_data);
    assign alu_b    = de.ctrl.alu_src_imm ? de.imm : op_b_reg;

    // ========================================
    // ALU
    // ========================================
    always_comb begin
        case (de.ctrl.alu_op)
            isa_pkg::alu_add:    alu_out = op_a + alu_b;
            isa_pkg::alu_sub:    alu_out = op_a - alu_b;
            isa_pkg::alu_and:    alu_out = op_a & alu_b;
            isa_pkg::alu_or:     alu_out = op_a | alu_b;
            isa_pkg::alu_xor:    alu_out = op_a ^ alu_b;
            isa_pkg::alu_slt:    alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
            isa_pkg::alu_sll:    alu_out = op_a << alu_b[4:0];
            isa_pkg::alu_srl:    alu_out = op_a >> alu_b[4:0];
            default:             alu_out = alu_b;
        endcase
    end

    // ========================================
    // Branch and jump resolution
    // ========================================
    always_comb begin
        case (de.ctrl.funct3)
            3'b000:  cond = (op_a == op_b_reg);
            3'b001:  cond = (op_a != op_b_reg);
            3'b100:  cond = ($signed(op_a) < $signed(op_b_reg));
            default: cond = 1'b0;
        endcase
    end

    assign link_pc = de.pc + 32'd4;
    // JALR base is rs1, bit 0 of its target is dropped
    assign target  = de.ctrl.jump_reg ? ((op_a + de.imm) & ~32'd1) : (de.pc + de.imm);

    assign redirect.taken  = de.valid && (de.ctrl.jump || (de.ctrl.branch && cond));
    assign redirect.target = target;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            em <= '0;
        end else if (!mem_stall) begin
            em.valid      <= de.valid;
            em.rd         <= de.rd;
            em.result     <= de.ctrl.link ? link_pc : alu_out;
            em.store_data <= op_b_reg;
            em.reg_write  <= de.valid && de.ctrl.reg_write;
            em.mem_read   <= de.valid && de.ctrl.mem_read;
            em.mem_write  <= de.valid && de.ctrl.mem_write;
        end
    end

endmodule

// File: fetch_stage.sv
// Instruction fetch
// Program counter, instruction request and the fetch/decode register
`timescale 1ns/100ps

module fetch_stage #(
    parameter isa_pkg::word_t reset_pc = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  isa_pkg::instr_t     imem_rdata,
    input  logic                imem_ready,
    input  pipe_pkg::redirect_t redirect,
    input  logic                load_use_stall,
    input  logic                mem_stall,
    output logic                imem_req,
    output isa_pkg::word_t      imem_addr,
    output pipe_pkg::fd_t       fd
);

    localparam pipe_pkg::fd_t fd_bubble = '{
        valid: 1'b0,
        pc:    '0,
        instr: isa_pkg::nop_instr
    };

    isa_pkg::word_t pc;
    logic           fetch_done;

    // No request while the fetched word could not be taken anyway
    assign imem_req   = !(mem_stall || load_use_stall);
    assign imem_addr  = pc;
    assign fetch_done = imem_req && imem_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
            fd <= fd_bubble;
        end else if (!mem_stall) begin
            if (redirect.taken) begin
                pc <= redirect.target;
                fd <= fd_bubble;
            end else if (!load_use_stall) begin
                if (fetch_done) begin
                    pc <= pc + 32'd4;
                    fd <= '{valid: 1'b1, pc: pc, instr: imem_rdata};
                end else begin
                    // Memory not ready, pc holds and decode sees a bubble
                    fd <= fd_bubble;
                end
            end
        end
    end

endmodule

// File: files.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_writeback.sv
rv32i_core.sv
tb_core.sv

// File: isa_pkg.sv
// RV32I instruction set definitions
// Word types, opcode and ALU operation encodings, and the NOP word
package isa_pkg;

    // Data width, fixed for the whole core
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;

    // ========================================
    // Major opcodes kept in this subset
    // ========================================
    typedef enum logic [6:0] {
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111
    } opcode_e;

    // ALU functions, pass_b serves LUI
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sll    = 4'd6,
        alu_srl    = 4'd7,
        alu_pass_b = 4'd8
    } alu_op_e;

    // ADDI x0, x0, 0
    localparam instr_t nop_instr = 32'h0000_0013;

endpackage

// File: memory_writeback.sv
// Memory access and writeback
// Data port, memory/writeback register and the forwarding sources
`timescale 1ns/100ps

module memory_writeback (
    input  logic           clk,
    input  logic           rst_n,
    input  pipe_pkg::em_t  em,
    input  isa_pkg::word_t dmem_rdata,
    input  logic           dmem_ready,
    output logic           dmem_req,
    output logic           dmem_we,
    output isa_pkg::word_t dmem_addr,
    output isa_pkg::word_t dmem_wdata,
    output logic           mem_stall,
    output pipe_pkg::fwd_t fwd_m,
    output pipe_pkg::fwd_t fwd_w
);

    pipe_pkg::mw_t mw;

    // ========================================
    // Data port
    // ========================================
    assign dmem_req   = em.valid && (em.mem_read || em.mem_write);
    assign dmem_we    = em.mem_write;
    assign dmem_addr  = em.result;
    assign dmem_wdata = em.store_data;

    // Request held until memory accepts it
    assign mem_stall = dmem_req && !dmem_ready;

    // Load data is not known yet in this stage
    assign fwd_m.valid = em.valid && em.reg_write && !em.mem_read && em.rd != '0;
    assign fwd_m.rd    = em.rd;
    assign fwd_m.data  = em.result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mw <= '0;
        end else if (!mem_stall) begin
            mw.valid     <= em.valid;
            mw.rd        <= em.rd;
            mw.wdata     <= em.mem_read ? dmem_rdata : em.result;
            mw.reg_write <= em.reg_write;
        end
    end

    // ========================================
    // Writeback
    // ========================================
    assign fwd_w.valid = mw.valid && mw.reg_write && mw.rd != '0;
    assign fwd_w.rd    = mw.rd;
    assign fwd_w.data  = mw.wdata;

endmodule

// File: pipe_pkg.sv
// Pipeline stage bundles
// Packed structs passed between fetch, decode, execute, memory and writeback
package pipe_pkg;

    // Fetch to decode
    typedef struct packed {
        logic             valid;
        isa_pkg::word_t   pc;
        isa_pkg::instr_t  instr;
    } fd_t;

    // Decoded control word
    typedef struct packed {
        logic             reg_write;
        logic             mem_read;
        logic             mem_write;
        logic             branch;
        logic             jump;
        logic             jump_reg;
        logic             alu_src_imm;
        isa_pkg::alu_op_e alu_op;
        // Result is pc+4 for JAL and JALR
        logic             link;
        logic [2:0]       funct3;
    } ctrl_t;

    // Decode to execute
    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    pc;
        isa_pkg::reg_idx_t rs1;
        isa_pkg::reg_idx_t rs2;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    rs1_data;
        isa_pkg::word_t    rs2_data;
        isa_pkg::word_t    imm;
        ctrl_t             ctrl;
    } de_t;

    // Execute to memory
    typedef struct packed {
        logic              valid;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    result;
        isa_pkg::word_t    store_data;
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
    } em_t;

    // Memory to writeback
    typedef struct packed {
        logic              valid;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    wdata;
        logic              reg_write;
    } mw_t;

    // Taken branch or jump, back to fetch
    typedef struct packed {
        logic           taken;
        isa_pkg::word_t target;
    } redirect_t;

    // Forwarding source, from the memory or writeback stage
    typedef struct packed {
        logic              valid;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    data;
    } fwd_t;

endpackage

// File: run.sh
#!/bin/sh
# Build and run the RV32I core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f files.f --top-module tb_core -o tb_core
./obj_dir/tb_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

// File: rv32i_core.sv
// RV32I five-stage pipeline core
// Fetch, decode, execute and memory/writeback stages joined into one core
`timescale 1ns/100ps

module rv32i_core #(
    parameter isa_pkg::word_t reset_pc = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    // Instruction port
    output logic            imem_req,
    output isa_pkg::word_t  imem_addr,
    input  isa_pkg::instr_t imem_rdata,
    input  logic            imem_ready,
    // Data port
    output logic            dmem_req,
    output logic            dmem_we,
    output isa_pkg::word_t  dmem_addr,
    output isa_pkg::word_t  dmem_wdata,
    input  isa_pkg::word_t  dmem_rdata,
    input  logic            dmem_ready
);

    pipe_pkg::fd_t       fd;
    pipe_pkg::de_t       de;
    pipe_pkg::em_t       em;
    pipe_pkg::redirect_t redirect;
    pipe_pkg::fwd_t      fwd_m;
    pipe_pkg::fwd_t      fwd_w;
    logic                load_use_stall;
    logic                mem_stall;

    fetch_stage #(.reset_pc(reset_pc)) fetch_i (
        .clk(clk), .rst_n(rst_n),
        .imem_rdata(imem_rdata), .imem_ready(imem_ready),
        .redirect(redirect), .load_use_stall(load_use_stall), .mem_stall(mem_stall),
        .imem_req(imem_req), .imem_addr(imem_addr), .fd(fd)
    );

    decode_stage decode_i (
        .clk(clk), .rst_n(rst_n),
        .fd(fd), .fwd_w(fwd_w), .redirect(redirect), .mem_stall(mem_stall),
        .de(de), .load_use_stall(load_use_stall)
    );

    execute_stage execute_i (
        .clk(clk), .rst_n(rst_n),
        .de(de), .fwd_m(fwd_m), .fwd_w(fwd_w), .mem_stall(mem_stall),
        .em(em), .redirect(redirect)
    );

    memory_writeback memwb_i (
        .clk(clk), .rst_n(rst_n),
        .em(em), .dmem_rdata(dmem_rdata), .dmem_ready(dmem_ready),
        .dmem_req(dmem_req), .dmem_we(dmem_we),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .mem_stall(mem_stall), .fwd_m(fwd_m), .fwd_w(fwd_w)
    );

endmodule

// File: tb_model.svh
// Test programs for the RV32I core testbench
// Small assembler, the four programs and a reference ISA model that predicts stores
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

task automatic append_word(isa_pkg::instr_t w);
    prog_mem[cur_prog][prog_len[cur_prog]] = w;
    prog_len[cur_prog]++;
endtask

// ========================================
// Instruction encoders
// ========================================
task automatic reg_op(logic [2:0] f3, logic alt, isa_pkg::reg_idx_t rd,
                      isa_pkg::reg_idx_t rs1, isa_pkg::reg_idx_t rs2);
    append_word({1'b0, alt, 5'b0, rs2, rs1, f3, rd, isa_pkg::op_reg});
endtask

task automatic imm_op(logic [2:0] f3, isa_pkg::reg_idx_t rd, isa_pkg::reg_idx_t rs1, int imm);
    append_word({imm[11:0], rs1, f3, rd, isa_pkg::op_imm});
endtask

task automatic load_word(isa_pkg::reg_idx_t rd, int imm, isa_pkg::reg_idx_t base);
    append_word({imm[11:0], base, 3'b010, rd, isa_pkg::op_load});
endtask

task automatic store_word(isa_pkg::reg_idx_t rs2, int imm, isa_pkg::reg_idx_t base);
    append_word({imm[11:5], rs2, base, 3'b010, imm[4:0], isa_pkg::op_store});
endtask

// Offsets counted in instructions
task automatic branch_to(logic [2:0] f3, isa_pkg::reg_idx_t rs1, isa_pkg::reg_idx_t rs2, int n);
    logic [12:0] off;
    off = 13'(n * 4);
    append_word({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], isa_pkg::op_branch});
endtask

task automatic jump_link(isa_pkg::reg_idx_t rd, int n);
    logic [20:0] off;
    off = 21'(n * 4);
    append_word({off[20], off[10:1], off[11], off[19:12], rd, isa_pkg::op_jal});
endtask

task automatic jump_reg_link(isa_pkg::reg_idx_t rd, isa_pkg::reg_idx_t rs1, int imm);
    append_word({imm[11:0], rs1, 3'b000, rd, isa_pkg::op_jalr});
endtask

// LUI plus ADDI, upper part rounded for the signed low part
task automatic load_const(isa_pkg::reg_idx_t rd, isa_pkg::word_t value);
    isa_pkg::word_t hi;
    hi = value + 32'h800;
    append_word({hi[31:12], rd, isa_pkg::op_lui});
    imm_op(3'd0, rd, rd, int'(value));
endtask

// Random constants in x1 and up, store base in x10
task automatic fill_regs(int pid, int count);
    cur_prog = pid;
    prog_len[pid] = 0;
    for (int r = 1; r <= count; r++) begin
        load_const(isa_pkg::reg_idx_t'(r), rand_bits(32));
    end
    imm_op(3'd0, 10, 0, 64);
endtask

// ========================================
// Programs 2 to 5
// ========================================
task automatic build_programs();
    // Back-to-back dependent ALU work
    fill_regs(2, 4);
    reg_op(3'd0, 1'b0, 5, 1, 2);
    reg_op(3'd0, 1'b1, 6, 5, 3);
    store_word(6, 0, 10);
    reg_op(3'd7, 1'b0, 7, 6, 1);
    reg_op(3'd6, 1'b0, 8, 7, 4);
    reg_op(3'd4, 1'b0, 9, 8, 5);
    store_word(9, 4, 10);
    reg_op(3'd2, 1'b0, 11, 9, 6);
    reg_op(3'd1, 1'b0, 12, 9, 3);
    reg_op(3'd5, 1'b0, 13, 12, 2);
    store_word(13, 8, 10);
    store_word(11, 12, 10);
    imm_op(3'd0, 14, 13, -123);
    imm_op(3'd4, 15, 14, 1365);
    imm_op(3'd6, 16, 15, -256);
    imm_op(3'd7, 17, 16, 2047);
    imm_op(3'd2, 18, 17, -5);
    imm_op(3'd1, 19, 15, 7);
    imm_op(3'd5, 20, 19, 13);
    store_word(17, 16, 10);
    store_word(18, 20, 10);
    store_word(20, 24, 10);
    store_word(1, 28, 10);
    jump_link(0, 0);

    // Loads, load-use on rs1 and rs2, load used as an address
    fill_regs(3, 2);
    store_word(1, 0, 10);
    load_word(5, 0, 10);
    reg_op(3'd0, 1'b0, 6, 5, 2);
    store_word(6, 4, 10);
    load_word(7, 4, 10);
    store_word(7, 8, 10);
    load_word(8, 40, 10);
    imm_op(3'd0, 9, 8, 1);
    store_word(9, 12, 10);
    load_word(11, 12, 10);
    load_word(12, 0, 10);
    reg_op(3'd0, 1'b1, 13, 11, 12);
    store_word(13, 16, 10);
    store_word(10, 20, 10);
    load_word(14, 20, 10);
    load_word(15, 0, 14);
    store_word(15, 24, 10);
    jump_link(0, 0);

    // Branches taken and not taken, JAL and JALR links, a short loop
    fill_regs(4, 2);
    imm_op(3'd0, 3, 1, 0);
    branch_to(3'd0, 1, 3, 2);
    store_word(1, 0, 10);
    store_word(2, 4, 10);
    branch_to(3'd1, 1, 3, 2);
    store_word(1, 8, 10);
    branch_to(3'd4, 1, 2, 2);
    store_word(2, 12, 10);
    branch_to(3'd4, 2, 1, 2);
    store_word(1, 16, 10);
    branch_to(3'd4, 1, 3, 2);
    store_word(2, 20, 10);
    jump_link(5, 3);
    store_word(1, 24, 10);
    store_word(1, 28, 10);
    store_word(5, 32, 10);
    jump_link(6, 2);
    store_word(2, 36, 10);
    imm_op(3'd0, 7, 6, 16);
    jump_reg_link(8, 7, 0);
    store_word(1, 40, 10);
    store_word(8, 44, 10);
    store_word(7, 48, 10);
    imm_op(3'd0, 9, 0, 3);
    imm_op(3'd0, 9, 9, -1);
    store_word(9, 52, 10);
    branch_to(3'd1, 9, 0, -2);
    jump_link(0, 0);

    // Every kind of write aimed at x0
    fill_regs(5, 1);
    load_const(0, rand_bits(32));
    store_word(0, 0, 10);
    reg_op(3'd0, 1'b0, 0, 1, 1);
    store_word(0, 4, 10);
    load_word(0, 8, 10);
    store_word(0, 8, 10);
    imm_op(3'd0, 0, 1, 1);
    reg_op(3'd0, 1'b0, 5, 0, 1);
    store_word(5, 12, 10);
    jump_link(0, 1);
    store_word(0, 16, 10);
    jump_link(0, 0);
endtask

// ========================================
// Reference model
// ========================================
function automatic isa_pkg::word_t alu_result(logic [2:0] f3, logic alt,
                                              isa_pkg::word_t a, isa_pkg::word_t b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd4:    return a ^ b;
        3'd5:    return a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

// Runs the program to its self loop and lists the stores it makes
task automatic run_model(int pid);
    isa_pkg::word_t  x [32];
    isa_pkg::word_t  pc;
    isa_pkg::word_t  npc;
    isa_pkg::word_t  a;
    isa_pkg::word_t  b;
    isa_pkg::word_t  addr;
    isa_pkg::instr_t w;
    logic [4:0]      rd;
    logic [2:0]      f3;
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < 64; i++) begin
        model_mem[i] = fill_word(i);
    end
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    pc = reset_pc;
    for (int step = 0; step < 1000; step++) begin
        w   = prog_mem[pid][pc[7:2]];
        rd  = w[11:7];
        f3  = w[14:12];
        a   = x[w[19:15]];
        b   = x[w[24:20]];
        npc = pc + 32'd4;
        case (isa_pkg::opcode_e'(w[6:0]))
            isa_pkg::op_lui: x[rd] = {w[31:12], 12'b0};
            isa_pkg::op_imm: x[rd] = alu_result(f3, 1'b0, a, {{20{w[31]}}, w[31:20]});
            isa_pkg::op_reg: x[rd] = alu_result(f3, w[30], a, b);
            isa_pkg::op_load: begin
                addr  = a + {{20{w[31]}}, w[31:20]};
                x[rd] = model_mem[addr[7:2]];
            end
            isa_pkg::op_store: begin
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                model_mem[addr[7:2]] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
            end
            isa_pkg::op_branch: begin
                if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b) ||
                    (f3 == 3'd4 && $signed(a) < $signed(b))) begin
                    npc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            isa_pkg::op_jal: begin
                x[rd] = pc + 32'd4;
                npc   = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            isa_pkg::op_jalr: begin
                npc   = (a + {{20{w[31]}}, w[31:20]}) & ~32'd1;
                x[rd] = pc + 32'd4;
            end
            default: npc = pc + 32'd4;
        endcase
        x[0] = '0;
        if (npc == pc) begin
            break;
        end
        pc = npc;
    end
endtask

`endif

// File: tb_core.sv
// Testbench for the RV32I pipeline core
// Runs each program with steady and random ready, checks stores against the model
`timescale 1ns/100ps

module tb_core;

    localparam isa_pkg::word_t reset_pc   = '0;
    localparam int             clk_period = 100;

    logic            clk        = 1'b0;
    logic            rst_n      = 1'b0;
    logic            imem_req;
    isa_pkg::word_t  imem_addr;
    isa_pkg::instr_t imem_rdata = isa_pkg::nop_instr;
    logic            imem_ready = 1'b0;
    logic            dmem_req;
    logic            dmem_we;
    isa_pkg::word_t  dmem_addr;
    isa_pkg::word_t  dmem_wdata;
    isa_pkg::word_t  dmem_rdata = '0;
    logic            dmem_ready = 1'b0;

    isa_pkg::instr_t prog_mem [6][64];
    int              prog_len [6];
    int              cur_prog = 2;
    isa_pkg::instr_t imem [64];
    isa_pkg::word_t  dmem [64];
    isa_pkg::word_t  model_mem [64];
    isa_pkg::word_t  exp_addr [$];
    isa_pkg::word_t  exp_data [$];
    logic [31:0]     lfsr = 32'h80d58028;
    logic            random_ready = 1'b0;
    logic            first_fetch_pending = 1'b1;
    int              store_idx = 0;
    int              stores_checked = 0;
    int              mismatches = 0;
    int              failures = 0;
    int              since_reset = 0;
    int              watchdog_cycles = 0;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic isa_pkg::word_t rand_bits(int n);
        isa_pkg::word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // Initial data memory contents, built from the byte address
    function automatic isa_pkg::word_t fill_word(int idx);
        isa_pkg::word_t a;
        a = isa_pkg::word_t'(idx) << 2;
        return 32'ha5a5_0000 ^ (a << 16) ^ a;
    endfunction

    `include "tb_model.svh"

    rv32i_core #(.reset_pc(reset_pc)) dut_i (
        .clk(clk), .rst_n(rst_n),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_rdata(imem_rdata), .imem_ready(imem_ready),
        .dmem_req(dmem_req), .dmem_we(dmem_we),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_rdata(dmem_rdata), .dmem_ready(dmem_ready)
    );

    always #(clk_period / 2) clk = ~clk;

    // ========================================
    // Memory models, driven on the falling edge
    // ========================================
    always @(negedge clk) begin
        if (random_ready) begin
            imem_ready <= lfsr_step();
            dmem_ready <= lfsr_step();
        end else begin
            imem_ready <= 1'b1;
            dmem_ready <= 1'b1;
        end
        imem_rdata <= imem[imem_addr[7:2]];
        dmem_rdata <= dmem[dmem_addr[7:2]];
    end

    // ========================================
    // Checks on the rising edge
    // ========================================
    always @(posedge clk) begin
        if (!rst_n || since_reset == 0) begin
            assert (!dmem_req) else begin
                failures++;
                $display("Data request raised during or just after reset at %0t", $time);
            end
        end
        if (!rst_n) begin
            // Program and data memory reloaded while the core is held
            for (int i = 0; i < 64; i++) begin
                imem[i] = (i < prog_len[cur_prog]) ? prog_mem[cur_prog][i] : isa_pkg::nop_instr;
                dmem[i] = fill_word(i);
            end
            first_fetch_pending = 1'b1;
            store_idx           = 0;
        end
        if (rst_n && imem_req && imem_ready && first_fetch_pending) begin
            first_fetch_pending = 1'b0;
            assert (imem_addr == reset_pc) else begin
                mismatches++;
                $display("MISMATCH at %0t: first fetch from %h, expected %h",
                         $time, imem_addr, reset_pc);
            end
        end
        if (rst_n && dmem_req && dmem_ready && dmem_we) begin
            assert (store_idx < exp_addr.size()) else begin
                failures++;
                $display("Store of %h to %h at %0t is beyond the expected store list",
                         dmem_wdata, dmem_addr, $time);
            end
            if (store_idx < exp_addr.size()) begin
                assert (dmem_addr == exp_addr[store_idx] && dmem_wdata == exp_data[store_idx])
                else begin
                    mismatches++;
                    $display("MISMATCH at %0t: store %0d wrote %h to %h, expected %h to %h",
                             $time, store_idx, dmem_wdata, dmem_addr,
                             exp_data[store_idx], exp_addr[store_idx]);
                end
            end
            dmem[dmem_addr[7:2]] = dmem_wdata;
            store_idx++;
            stores_checked++;
        end
        since_reset = rst_n ? since_reset + 1 : 0;
    end

    // Request held steady while memory makes it wait
    assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req && !dmem_ready |=> dmem_req && $stable(dmem_we) && $stable(dmem_addr)
            && $stable(dmem_wdata))
    else begin
        failures++;
        $display("Data request changed while waiting for ready at %0t", $time);
    end

    task automatic run_program(int pid, logic use_random);
        @(negedge clk);
        rst_n        = 1'b0;
        cur_prog     = pid;
        random_ready = use_random;
        run_model(pid);
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        while (store_idx < exp_addr.size()) begin
            @(posedge clk);
        end
        // Spin in the final loop so any stray store still shows up
        repeat (20) @(posedge clk);
    endtask

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the runs did not finish within %0d cycles", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        int total;
        build_programs();
        total = 0;
        for (int p = 2; p <= 5; p++) begin
            total += prog_len[p];
        end
        // Two runs per program, 40 cycles per instruction, 4x for random stalls
        watchdog_cycles = total * 2 * 40 * 4;
        for (int pass = 0; pass < 2; pass++) begin
            for (int p = 2; p <= 5; p++) begin
                run_program(p, pass == 1);
            end
        end
        $display("Errors: %0d mismatches, %0d other failures, %0d stores checked",
                 mismatches, failures, stores_checked);
        if (mismatches == 0 && failures == 0 && stores_checked > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
